/* rtl/acelp_pkg.sv */
package acelp_pkg;

	//////////////////////////////////////////////////
	// Widths and limits
	//////////////////////////////////////////////////

	// Scratch address width used inside the structs
	localparam int CMD_ADDR_W = 12;
	localparam int WORD_W = 16;

	// 16-bit signed saturation bounds
	localparam int WORD_MAX = 32767;
	localparam int WORD_MIN = -32768;

	// Left shifts of 16 or more always clip a nonzero word
	localparam int SHL_SAT_CNT = 16;
	// Right shifts of 15 or more leave only the sign
	localparam int SHR_MAX_CNT = 15;

	//////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////

	typedef enum logic [1:0]
	{
		OP_ADD = 2'd0,
		OP_SUB = 2'd1,
		OP_SHL = 2'd2,
		OP_SHR = 2'd3
	} op_e;

	typedef logic signed [WORD_W-1:0] word_t;

	// Host command of 42 bits
	typedef struct packed
	{
		op_e                   opcode;
		logic [CMD_ADDR_W-1:0] src_addr;
		logic [CMD_ADDR_W-1:0] dst_addr;
		word_t                 imm;
	} acelp_cmd_t;

	// Result stream entry of 29 bits
	typedef struct packed
	{
		logic [CMD_ADDR_W-1:0] dst_addr;
		word_t                 value;
		logic                  overflow;
	} acelp_res_t;

	// Record handed from decode to execute and on to writeback
	typedef struct packed
	{
		op_e                   opcode;
		logic [CMD_ADDR_W-1:0] dst_addr;
		word_t                 imm;
		word_t                 value;
		logic                  overflow;
	} op_stage_t;

endpackage

/* rtl/scratch_memory.sv */
module scratch_memory #(
	parameter int ADDR_W = 12
) (
	input  logic              clk,
	input  logic              wea,
	input  logic [ADDR_W-1:0] addra,
	input  acelp_pkg::word_t  dina,
	input  logic [ADDR_W-1:0] addrb,
	output acelp_pkg::word_t  doutb
);
	import acelp_pkg::*;

	localparam int DEPTH = 2 ** ADDR_W;

	word_t mem [DEPTH];

	// Port A write
	always_ff @(posedge clk)
	begin
		if (wea)
			mem[addra] <= dina;
	end

	// Port B registered read
	always_ff @(posedge clk)
	begin
		// Same-edge write to the read address wins
		if (wea && (addra == addrb))
			doutb <= dina;
		else
			doutb <= mem[addrb];
	end

endmodule

/* rtl/cmd_decode.sv */
module cmd_decode #(
	parameter int ADDR_W = 12
) (
	input  logic                  clk,
	input  logic                  reset,
	input  acelp_pkg::acelp_cmd_t cmd,
	input  logic                  cmd_valid,
	output logic                  cmd_ready,
	input  logic                  host_mode,
	input  logic [ADDR_W-1:0]     ex_busy_addr,
	input  logic [ADDR_W-1:0]     wb_busy_addr,
	input  logic                  ex_busy,
	input  logic                  wb_busy,
	output logic [ADDR_W-1:0]     rd_addr,
	output acelp_pkg::op_stage_t  dec_stage,
	output logic                  dec_valid
);
	import acelp_pkg::*;

	logic [ADDR_W-1:0] src_addr;
	logic              ex_hazard;
	logic              wb_hazard;
	logic              hazard;
	logic              run_en;
	logic              accept;
	op_stage_t         next_stage;

	//////////////////////////////////////////////////
	// Hazard check and handshake
	//////////////////////////////////////////////////

	assign src_addr = cmd.src_addr[ADDR_W-1:0];

	// Source still waiting on an older result that is not yet written
	assign ex_hazard = ex_busy && (src_addr == ex_busy_addr);
	assign wb_hazard = wb_busy && (src_addr == wb_busy_addr);
	assign hazard    = ex_hazard || wb_hazard;

	// Held low through reset and opens one cycle after release
	always_ff @(posedge clk)
	begin
		if (reset)
			run_en <= 1'b0;
		else
			run_en <= 1'b1;
	end

	assign cmd_ready = !reset && run_en && !host_mode && !hazard;
	assign accept    = cmd_valid && cmd_ready;

	// Memory samples this on the accepting edge
	assign rd_addr = src_addr;

	//////////////////////////////////////////////////
	// Stage register
	//////////////////////////////////////////////////

	always_comb
	begin
		next_stage          = '0;
		next_stage.opcode   = cmd.opcode;
		next_stage.dst_addr = cmd.dst_addr;
		next_stage.imm      = cmd.imm;
		// value and overflow are filled in by execute
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			dec_valid <= 1'b0;
		else
			dec_valid <= accept;
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			dec_stage <= next_stage;
	end

endmodule

/* rtl/basic_op_unit.sv */
module basic_op_unit (
	input  logic                 clk,
	input  logic                 reset,
	input  acelp_pkg::op_stage_t dec_stage,
	input  logic                 dec_valid,
	input  acelp_pkg::word_t     mem_word,
	output acelp_pkg::op_stage_t ex_stage,
	output logic                 ex_valid
);
	import acelp_pkg::*;

	word_t              a;
	word_t              b;
	logic signed [16:0] left_cnt;
	logic signed [16:0] right_cnt;
	logic [4:0]         sh_l;
	logic [3:0]         sh_r;
	logic signed [31:0] wide;
	logic [16:0]        sat_res;
	op_stage_t          next_stage;

	// Clip to 16 bits with the overflow flag as the top bit
	function automatic logic [16:0] sat_word(input logic signed [31:0] x);
		logic [16:0] r;
		if (x > WORD_MAX)
			r = {1'b1, 16'(WORD_MAX)};
		else if (x < WORD_MIN)
			r = {1'b1, 16'(WORD_MIN)};
		else
			r = {1'b0, x[15:0]};
		return r;
	endfunction

	//////////////////////////////////////////////////
	// Shift count handling
	//////////////////////////////////////////////////

	always_comb
	begin
		a = mem_word;
		b = dec_stage.imm;

		// shr by n is shl by -n, so fold both into one signed left count
		if (dec_stage.opcode == OP_SHR)
			left_cnt = -17'(b);
		else
			left_cnt = 17'(b);
		right_cnt = -left_cnt;

		if (left_cnt > 17'(SHL_SAT_CNT))
			sh_l = 5'(SHL_SAT_CNT);
		else if (left_cnt >= 0)
			sh_l = left_cnt[4:0];
		else
			sh_l = 5'd0;

		if (right_cnt > 17'(SHR_MAX_CNT))
			sh_r = 4'(SHR_MAX_CNT);
		else if (right_cnt >= 0)
			sh_r = right_cnt[3:0];
		else
			sh_r = 4'd0;
	end

	//////////////////////////////////////////////////
	// Operation and saturation
	//////////////////////////////////////////////////

	always_comb
	begin
		case (dec_stage.opcode)
			OP_ADD: wide = 32'(a) + 32'(b);
			OP_SUB: wide = 32'(a) - 32'(b);
			OP_SHL,
			OP_SHR:
			begin
				// Only the left path can clip
				if (left_cnt >= 0)
					wide = 32'(a) <<< sh_l;
				else
					wide = 32'(a >>> sh_r);
			end
			default: wide = 32'(a);
		endcase

		sat_res             = sat_word(wide);
		next_stage          = dec_stage;
		next_stage.value    = sat_res[15:0];
		next_stage.overflow = sat_res[16];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			ex_valid <= 1'b0;
		else
			ex_valid <= dec_valid;
	end

	always_ff @(posedge clk)
	begin
		if (dec_valid)
			ex_stage <= next_stage;
	end

endmodule

/* rtl/result_writeback.sv */
module result_writeback #(
	parameter int ADDR_W = 12
) (
	input  logic                  clk,
	input  logic                  reset,
	input  acelp_pkg::op_stage_t  ex_stage,
	input  logic                  ex_valid,
	output acelp_pkg::acelp_res_t res,
	output logic                  res_valid,
	output logic                  wr_en,
	output logic [ADDR_W-1:0]     wr_addr,
	output acelp_pkg::word_t      wr_data
);
	import acelp_pkg::*;

	acelp_res_t next_res;

	always_comb
	begin
		next_res.dst_addr = ex_stage.dst_addr;
		next_res.value    = ex_stage.value;
		next_res.overflow = ex_stage.overflow;
	end

	//////////////////////////////////////////////////
	// Result register
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
			res_valid <= 1'b0;
		else
			res_valid <= ex_valid;
	end

	always_ff @(posedge clk)
	begin
		if (ex_valid)
			res <= next_res;
	end

	// Scratch write lands on the edge that retires the result
	assign wr_en   = res_valid;
	assign wr_addr = res.dst_addr[ADDR_W-1:0];
	assign wr_data = res.value;

endmodule

/* rtl/de_acelp_pipe.sv */
module de_acelp_pipe #(
	parameter int ADDR_W = 12
) (
	input  logic                  clk,
	input  logic                  reset,
	input  acelp_pkg::acelp_cmd_t cmd,
	input  logic                  cmd_valid,
	output logic                  cmd_ready,
	output acelp_pkg::acelp_res_t res,
	output logic                  res_valid,
	input  logic                  host_mode,
	input  logic                  host_wr_en,
	input  logic [ADDR_W-1:0]     host_wr_addr,
	input  logic [ADDR_W-1:0]     host_rd_addr,
	input  acelp_pkg::word_t      host_wr_data,
	output acelp_pkg::word_t      host_rd_data
);
	import acelp_pkg::*;

	op_stage_t         dec_stage;
	logic              dec_valid;
	op_stage_t         ex_stage;
	logic              ex_valid;
	logic [ADDR_W-1:0] pipe_rd_addr;
	logic              pipe_wr_en;
	logic [ADDR_W-1:0] pipe_wr_addr;
	word_t             pipe_wr_data;
	logic [ADDR_W-1:0] mem_wr_addr;
	word_t             mem_wr_data;
	logic              mem_wr_en;
	logic [ADDR_W-1:0] mem_rd_addr;
	word_t             mem_rd_data;
	logic [ADDR_W-1:0] ex_busy_addr;
	logic [ADDR_W-1:0] wb_busy_addr;

	//////////////////////////////////////////////////
	// Pipeline stages
	//////////////////////////////////////////////////

	// Execute works on the decode register, writeback on the execute register
	assign ex_busy_addr = dec_stage.dst_addr[ADDR_W-1:0];
	assign wb_busy_addr = ex_stage.dst_addr[ADDR_W-1:0];

	cmd_decode #(.ADDR_W(ADDR_W)) i_cmd_decode (
		.clk(clk), .reset(reset), .cmd(cmd), .cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready), .host_mode(host_mode),
		.ex_busy_addr(ex_busy_addr), .wb_busy_addr(wb_busy_addr),
		.ex_busy(dec_valid), .wb_busy(ex_valid), .rd_addr(pipe_rd_addr),
		.dec_stage(dec_stage), .dec_valid(dec_valid)
	);

	basic_op_unit i_basic_op_unit (
		.clk(clk), .reset(reset), .dec_stage(dec_stage), .dec_valid(dec_valid),
		.mem_word(mem_rd_data), .ex_stage(ex_stage), .ex_valid(ex_valid)
	);

	result_writeback #(.ADDR_W(ADDR_W)) i_result_writeback (
		.clk(clk), .reset(reset), .ex_stage(ex_stage), .ex_valid(ex_valid),
		.res(res), .res_valid(res_valid), .wr_en(pipe_wr_en),
		.wr_addr(pipe_wr_addr), .wr_data(pipe_wr_data)
	);

	//////////////////////////////////////////////////
	// Host access muxes
	//////////////////////////////////////////////////

	// Write address
	always_comb
	begin
		case (host_mode)
			1'b0: mem_wr_addr = pipe_wr_addr;
			1'b1: mem_wr_addr = host_wr_addr;
		endcase
	end

	// Write data
	always_comb
	begin
		case (host_mode)
			1'b0: mem_wr_data = pipe_wr_data;
			1'b1: mem_wr_data = host_wr_data;
		endcase
	end

	// Write enable
	always_comb
	begin
		case (host_mode)
			1'b0: mem_wr_en = pipe_wr_en;
			1'b1: mem_wr_en = host_wr_en;
		endcase
	end

	// Read address
	always_comb
	begin
		case (host_mode)
			1'b0: mem_rd_addr = pipe_rd_addr;
			1'b1: mem_rd_addr = host_rd_addr;
		endcase
	end

	scratch_memory #(.ADDR_W(ADDR_W)) i_scratch_memory (
		.clk(clk), .wea(mem_wr_en), .addra(mem_wr_addr), .dina(mem_wr_data),
		.addrb(mem_rd_addr), .doutb(mem_rd_data)
	);

	assign host_rd_data = mem_rd_data;

endmodule

/* bench/de_acelp_pipe_assert.sv */
module de_acelp_pipe_assert #(
	parameter int ADDR_W = 12
) (
	input logic                  clk,
	input logic                  reset,
	input acelp_pkg::acelp_cmd_t cmd,
	input logic                  cmd_valid,
	input logic                  cmd_ready,
	input logic                  host_mode,
	input logic                  dec_valid,
	input logic                  ex_valid,
	input logic                  res_valid
);
	int fail_count = 0;

	// Command held steady until the transfer edge
	cmd_stable: assert property (@(posedge clk) disable iff (reset)
		cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd))
	else
	begin
		$error("cmd changed or dropped while waiting for cmd_ready");
		fail_count++;
	end

	// Source reads the destination accepted on the previous edge
	hazard_stall: assert property (@(posedge clk) disable iff (reset)
		$past(cmd_valid && cmd_ready)
		&& (cmd.src_addr[ADDR_W-1:0] == $past(cmd.dst_addr[ADDR_W-1:0]))
		|-> !cmd_ready)
	else
	begin
		$error("cmd_ready high on a read-after-write hazard");
		fail_count++;
	end

	host_mode_idle: assert property (@(posedge clk) disable iff (reset)
		$rose(host_mode) |-> !(dec_valid || ex_valid || res_valid))
	else
	begin
		$error("host_mode raised with a command in flight");
		fail_count++;
	end

endmodule

bind de_acelp_pipe de_acelp_pipe_assert #(.ADDR_W(ADDR_W)) pipe_assert (
	.clk(clk), .reset(reset), .cmd(cmd), .cmd_valid(cmd_valid),
	.cmd_ready(cmd_ready), .host_mode(host_mode), .dec_valid(dec_valid),
	.ex_valid(ex_valid), .res_valid(res_valid)
);

/* bench/tb_de_acelp_pipe.sv */
module tb_de_acelp_pipe;
	import acelp_pkg::*;

	localparam int ADDR_W = 12;
	localparam int STALL_LIMIT = 50;

	// One parsed trace line
	// W lines use dst and imm and R lines use src and exp_value
	typedef struct packed
	{
		logic [7:0]         kind;
		logic [1:0]         opcode;
		logic [11:0]        src;
		logic [11:0]        dst;
		logic signed [15:0] imm;
		logic signed [15:0] exp_value;
		logic               exp_ovf;
	} trace_op_t;

	logic              clk;
	logic              reset;
	acelp_cmd_t        cmd;
	logic              cmd_valid;
	logic              cmd_ready;
	acelp_res_t        res;
	logic              res_valid;
	logic              host_mode;
	logic              host_wr_en;
	logic [ADDR_W-1:0] host_wr_addr;
	logic [ADDR_W-1:0] host_rd_addr;
	word_t             host_wr_data;
	word_t             host_rd_data;

	trace_op_t  ops[$];
	acelp_res_t exp_q[$];
	acelp_res_t exp_res;
	// Last expected word per command destination
	word_t      last_dst_word[int];
	int         check_count = 0;
	int         mismatch_count = 0;
	int         other_count = 0;
	int         cycle_count = 0;
	int         cycle_limit = 100;
	bit         stalled = 1'b0;

	de_acelp_pipe #(.ADDR_W(ADDR_W)) DUT (
		.clk(clk), .reset(reset), .cmd(cmd), .cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready), .res(res), .res_valid(res_valid),
		.host_mode(host_mode), .host_wr_en(host_wr_en),
		.host_wr_addr(host_wr_addr), .host_rd_addr(host_rd_addr),
		.host_wr_data(host_wr_data), .host_rd_data(host_rd_data)
	);

	initial
		clk = 1'b0;
	always #5 clk = ~clk;

	task automatic check_value(input string name, input int expected, input int actual);
		check_count++;
		if (expected != actual)
		begin
			mismatch_count++;
			$display("MISMATCH at %0t: %s expected %0d, actual %0d",
				$time, name, expected, actual);
		end
	endtask

	//////////////////////////////////////////////////
	// Result monitor and timeout
	//////////////////////////////////////////////////

	// Results come back in command order
	always @(negedge clk)
	begin
		if (!reset && res_valid)
		begin
			if (exp_q.size() == 0)
			begin
				other_count++;
				$display("ERROR at %0t: result seen with no command pending", $time);
			end
			else
			begin
				exp_res = exp_q.pop_front();
				check_value("res.dst_addr", int'(exp_res.dst_addr), int'(res.dst_addr));
				check_value("res.value", int'(exp_res.value), int'(res.value));
				check_value("res.overflow", int'(exp_res.overflow), int'(res.overflow));
			end
		end
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > cycle_limit)
		begin
			$display("ERROR: run hung, not finished after %0d cycles", cycle_limit);
			$display("Result: FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Trace reading and drivers
	//////////////////////////////////////////////////

	task automatic read_trace();
		int        fd;
		int        n;
		int        f_op;
		int        f_src;
		int        f_dst;
		int        f_imm;
		int        f_val;
		int        f_ovf;
		string     line;
		string     body;
		trace_op_t op;
		fd = $fopen("bench/acelp_trace.txt", "r");
		if (fd == 0)
		begin
			other_count++;
			$display("ERROR: trace file bench/acelp_trace.txt could not be opened");
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			n = $fgets(line, fd);
			if (n < 2 || line.getc(0) == "#")
				continue;
			op = '0;
			op.kind = line.getc(0);
			body = line.substr(1, line.len() - 1);
			f_op = 0;
			f_src = 0;
			f_dst = 0;
			f_imm = 0;
			f_val = 0;
			f_ovf = 0;
			case (op.kind)
				"W": n = $sscanf(body, "%h %d", f_dst, f_imm) + 4;
				"R": n = $sscanf(body, "%h %d", f_src, f_val) + 4;
				"C": n = $sscanf(body, "%d %h %h %d %d %d",
					f_op, f_src, f_dst, f_imm, f_val, f_ovf);
				default: n = 0;
			endcase
			if (n != 6)
			begin
				other_count++;
				$display("ERROR: trace line not understood: %s", line);
				continue;
			end
			op.opcode = 2'(f_op);
			op.src = 12'(f_src);
			op.dst = 12'(f_dst);
			op.imm = 16'(f_imm);
			op.exp_value = 16'(f_val);
			op.exp_ovf = 1'(f_ovf);
			ops.push_back(op);
		end
		$fclose(fd);
		cycle_limit = 20 * ops.size() + 100;
	endtask

	// Waits until every accepted command has been written back
	task automatic drain_pipe();
		while (exp_q.size() != 0 || res_valid)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic enter_host_mode();
		if (!host_mode)
		begin
			drain_pipe();
			host_mode = 1'b1;
		end
	endtask

	task automatic send_cmd(input trace_op_t op);
		acelp_res_t entry;
		int         stall;
		stall = 0;
		host_mode = 1'b0;
		host_wr_en = 1'b0;
		cmd.opcode = op_e'(op.opcode);
		cmd.src_addr = op.src;
		cmd.dst_addr = op.dst;
		cmd.imm = op.imm;
		cmd_valid = 1'b1;
		@(negedge clk);
		while (!cmd_ready)
		begin
			stall++;
			if (stall > STALL_LIMIT)
			begin
				other_count++;
				$display("ERROR at %0t: handshake stalled, cmd_ready low for %0d cycles",
					$time, STALL_LIMIT);
				stalled = 1'b1;
				return;
			end
			@(negedge clk);
		end
		entry.dst_addr = op.dst;
		entry.value = op.exp_value;
		entry.overflow = op.exp_ovf;
		exp_q.push_back(entry);
		last_dst_word[int'(op.dst)] = op.exp_value;
		@(posedge clk);
		#1;
		cmd_valid = 1'b0;
	endtask

	task automatic host_write(input trace_op_t op);
		enter_host_mode();
		host_wr_en = 1'b1;
		host_wr_addr = op.dst;
		host_wr_data = op.imm;
		@(posedge clk);
		#1;
		host_wr_en = 1'b0;
	endtask

	task automatic host_read(input trace_op_t op);
		enter_host_mode();
		host_rd_addr = op.src;
		@(posedge clk);
		#1;
		check_value("host_rd_data", int'(op.exp_value), int'(host_rd_data));
	endtask

	// Reads back the last word written to every command destination
	task automatic verify_destinations();
		trace_op_t op;
		foreach (last_dst_word[addr])
		begin
			op = '0;
			op.src = 12'(addr);
			op.exp_value = last_dst_word[addr];
			host_read(op);
		end
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial
	begin
		int total;
		reset = 1'b1;
		cmd = '0;
		cmd_valid = 1'b0;
		host_mode = 1'b0;
		host_wr_en = 1'b0;
		host_wr_addr = '0;
		host_rd_addr = '0;
		host_wr_data = '0;
		read_trace();
		repeat (4) @(posedge clk);
		#1;
		// Handshake and result stream stay idle through reset
		check_value("cmd_ready", 0, int'(cmd_ready));
		check_value("res_valid", 0, int'(res_valid));
		reset = 1'b0;
		for (int i = 0; i < ops.size() && !stalled; i++)
		begin
			case (ops[i].kind)
				"C": send_cmd(ops[i]);
				"W": host_write(ops[i]);
				default: host_read(ops[i]);
			endcase
		end
		if (!stalled)
		begin
			drain_pipe();
			verify_destinations();
		end
		total = mismatch_count + other_count + DUT.pipe_assert.fail_count;
		$display("Checks: %0d, mismatches: %0d, other errors: %0d, assertion failures: %0d",
			check_count, mismatch_count, other_count, DUT.pipe_assert.fail_count);
		if (total == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* bench/acelp_trace.txt */
# W addr data | R addr expected_data | C op src dst imm expected_value expected_overflow
# op: 0 add, 1 sub, 2 shl, 3 shr; addresses hex, data decimal
W 010 1000
W 011 -2000
W 012 30000
W 013 -30000
W 014 1
W 016 4660
W 017 -16384
W 100 7
R 010 1000
R 017 -16384
C 0 010 020 234 1234 0
C 1 011 021 500 -2500 0
C 0 012 022 5000 32767 1
C 1 013 023 5000 -32768 1
C 1 012 024 -2767 32767 0
C 2 014 025 4 16 0
C 2 016 026 3 32767 1
C 2 017 027 1 -32768 0
C 2 016 028 -4 291 0
C 2 014 029 20 32767 1
C 3 011 02A 3 -250 0
C 3 011 02B 20 -1 0
C 3 014 02C -3 8 0
C 3 012 02D -1 32767 1
C 0 100 101 5 12 0
C 0 101 102 10 22 0
C 2 102 103 2 88 0
C 1 103 103 100 -12 0
C 3 103 103 1 -6 0
R 020 1234
R 023 -32768
R 02D 32767
R 102 22
R 103 -6

/* de_acelp_pipe.f */
rtl/acelp_pkg.sv
rtl/scratch_memory.sv
rtl/cmd_decode.sv
rtl/basic_op_unit.sv
rtl/result_writeback.sv
rtl/de_acelp_pipe.sv
bench/de_acelp_pipe_assert.sv
bench/tb_de_acelp_pipe.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, verdict taken from the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_de_acelp_pipe \
	-f de_acelp_pipe.f \
	-o sim_de_acelp_pipe

./obj_dir/sim_de_acelp_pipe +verilator+error+limit+100 | tee sim.log

if grep -q "^Result: PASSED$" sim.log; then
	exit 0
else
	exit 1
fi
